//--- decoder_tests.txt
# inst we rd rs1 rs2 alu_op alu_src imm branch jump jalr mem_read mem_write mem_size
# load_unsigned word_op illegal ebreak, and any text after the last column is the assembly
002081b3 1 3 1 2 0 0 0000000000000000 0 0 0 0 0 0 0 0 0 0  add x3, x1, x2
407302b3 1 5 6 7 1 0 0000000000000000 0 0 0 0 0 0 0 0 0 0  sub x5, x6, x7
02c58533 1 10 11 12 10 0 0000000000000000 0 0 0 0 0 0 0 0 0 0  mul x10, x11, x12
02f776b3 1 13 14 15 14 0 0000000000000000 0 0 0 0 0 0 0 0 0 0  remu x13, x14, x15
003120b3 1 1 2 3 5 0 0000000000000000 0 0 0 0 0 0 0 0 0 0  slt x1, x2, x3
0062b233 1 4 5 6 6 0 0000000000000000 0 0 0 0 0 0 0 0 0 0  sltu x4, x5, x6
fff10093 1 1 2 0 0 1 ffffffffffffffff 0 0 0 0 0 0 0 0 0 0  addi x1, x2, -1
0f04f413 1 8 9 0 2 1 00000000000000f0 0 0 0 0 0 0 0 0 0 0  andi x8, x9, 0xf0
80024193 1 3 4 0 4 1 fffffffffffff800 0 0 0 0 0 0 0 0 0 0  xori x3, x4, -2048
7ff2e293 1 5 5 0 3 1 00000000000007ff 0 0 0 0 0 0 0 0 0 0  ori x5, x5, 0x7ff
03f39313 1 6 7 0 7 1 000000000000003f 0 0 0 0 0 0 0 0 0 0  slli x6, x7, 63
42155493 1 9 10 0 9 1 0000000000000021 0 0 0 0 0 0 0 0 0 0  srai x9, x10, 33
003100bb 1 1 2 3 0 0 0000000000000000 0 0 0 0 0 0 0 1 0 0  addw x1, x2, x3
4062823b 1 4 5 6 1 0 0000000000000000 0 0 0 0 0 0 0 1 0 0  subw x4, x5, x6
009413bb 1 7 8 9 7 0 0000000000000000 0 0 0 0 0 0 0 1 0 0  sllw x7, x8, x9
40c5d53b 1 10 11 12 9 0 0000000000000000 0 0 0 0 0 0 0 1 0 0  sraw x10, x11, x12
02f746bb 1 13 14 15 11 0 0000000000000000 0 0 0 0 0 0 0 1 0 0  divw x13, x14, x15
ffb1009b 1 1 2 0 0 1 fffffffffffffffb 0 0 0 0 0 0 0 1 0 0  addiw x1, x2, -5
41f2519b 1 3 4 0 9 1 000000000000001f 0 0 0 0 0 0 0 1 0 0  sraiw x3, x4, 31
00812283 1 5 2 0 0 1 0000000000000008 0 0 0 1 0 2 0 0 0 0  lw x5, 8(x2)
ff01b303 1 6 3 0 0 1 fffffffffffffff0 0 0 0 1 0 3 0 0 0 0  ld x6, -16(x3)
00124383 1 7 4 0 0 1 0000000000000001 0 0 0 1 0 0 1 0 0 0  lbu x7, 1(x4)
00229403 1 8 5 0 0 1 0000000000000002 0 0 0 1 0 1 0 0 0 0  lh x8, 2(x5)
ffe35483 1 9 6 0 0 1 fffffffffffffffe 0 0 0 1 0 1 1 0 0 0  lhu x9, -2(x6)
00110023 0 0 2 1 0 1 0000000000000000 0 0 0 0 1 0 0 0 0 0  sb x1, 0(x2)
00321323 0 0 4 3 0 1 0000000000000006 0 0 0 0 1 1 0 0 0 0  sh x3, 6(x4)
fe532e23 0 0 6 5 0 1 fffffffffffffffc 0 0 0 0 1 2 0 0 0 0  sw x5, -4(x6)
02743423 0 0 8 7 0 1 0000000000000028 0 0 0 0 1 3 0 0 0 0  sd x7, 40(x8)
00208463 0 0 1 2 15 0 0000000000000008 1 0 0 0 0 0 0 0 0 0  beq x1, x2, 8
fe419ee3 0 0 3 4 16 0 fffffffffffffffc 1 0 0 0 0 0 0 0 0 0  bne x3, x4, -4
0062c863 0 0 5 6 17 0 0000000000000010 1 0 0 0 0 0 0 0 0 0  blt x5, x6, 16
0083d0e3 0 0 7 8 18 0 0000000000000800 1 0 0 0 0 0 0 0 0 0  bge x7, x8, 2048
02a4e063 0 0 9 10 19 0 0000000000000020 1 0 0 0 0 0 0 0 0 0  bltu x9, x10, 32
80c5f063 0 0 11 12 20 0 fffffffffffff000 1 0 0 0 0 0 0 0 0 0  bgeu x11, x12, -4096
001000ef 1 1 0 0 0 2 0000000000000800 0 1 0 0 0 0 0 0 0 0  jal x1, 2048
fffff2ef 1 5 0 0 0 2 fffffffffffffffe 0 1 0 0 0 0 0 0 0 0  jal x5, -2
00c280e7 1 1 5 0 0 2 000000000000000c 0 1 1 0 0 0 0 0 0 0  jalr x1, 12(x5)
80000537 1 10 0 0 0 1 ffffffff80000000 0 0 0 0 0 0 0 0 0 0  lui x10, 0x80000
12345597 1 11 0 0 0 3 0000000012345000 0 0 0 0 0 0 0 0 0 0  auipc x11, 0x12345
00100073 0 0 0 0 0 0 0000000000000000 0 0 0 0 0 0 0 0 0 1  ebreak
00000073 0 0 0 0 0 0 0000000000000000 0 0 0 0 0 0 0 0 1 0  ecall is not decoded
ffffffff 0 0 0 0 0 0 0000000000000000 0 0 0 0 0 0 0 0 1 0  unknown opcode
023110b3 0 0 0 0 0 0 0000000000000000 0 0 0 0 0 0 0 0 1 0  mulh x1, x2, x3
0201109b 0 0 0 0 0 0 0000000000000000 0 0 0 0 0 0 0 0 1 0  slliw with shamt bit 5 set
00017083 0 0 0 0 0 0 0000000000000000 0 0 0 0 0 0 0 0 1 0  load with funct3 7

//--- sources.f
+incdir+.
rv_isa_pkg.sv
rv_ctrl_pkg.sv
ctrl_decode.sv
decode_pipe_reg.sv
imm_gen.sv
rv_decoder_top.sv
tb_rv_decoder.sv

//--- tb_rv_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_decoder_config.svh"

module tb_rv_decoder;

    localparam int MAX_TESTS = 64;
    localparam int TIMEOUT_CYCLES = 20;
    localparam int LATENCY = 2;   // drive negedge to output negedge, in counted edges

    logic                       clk = 1'b0;
    logic                       reset;
    logic                       inst_valid;
    logic [`INST_WIDTH-1:0]     inst;
    logic                       out_valid;
    logic                       reg_wen;
    logic [`REG_ADDR_WIDTH-1:0] rd;
    logic [`REG_ADDR_WIDTH-1:0] rs1;
    logic [`REG_ADDR_WIDTH-1:0] rs2;
    logic [4:0]                 alu_op;
    logic [1:0]                 alu_src;
    logic                       branch;
    logic                       jump;
    logic                       jalr;
    logic                       mem_read;
    logic                       mem_write;
    logic [1:0]                 mem_size;
    logic                       load_unsigned;
    logic                       word_op;
    logic                       illegal;
    logic                       ebreak;
    logic [`XLEN-1:0]           imm;

    logic [63:0] vec [0:MAX_TESTS-1][0:17];   // column order of the data file
    int          num_tests = 0;
    int          cycle = 0;
    int          error_count = 0;
    int          pass_count = 0;
    int          fail_count = 0;
    integer      seed = 40420;
    int          idx_q[$];
    int          due_q[$];

    always #20 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    rv_decoder_top dut_i (
        .clk           (clk),
        .reset         (reset),
        .inst_valid    (inst_valid),
        .inst          (inst),
        .out_valid     (out_valid),
        .reg_wen       (reg_wen),
        .rd            (rd),
        .rs1           (rs1),
        .rs2           (rs2),
        .alu_op        (alu_op),
        .alu_src       (alu_src),
        .branch        (branch),
        .jump          (jump),
        .jalr          (jalr),
        .mem_read      (mem_read),
        .mem_write     (mem_write),
        .mem_size      (mem_size),
        .load_unsigned (load_unsigned),
        .word_op       (word_op),
        .illegal       (illegal),
        .ebreak        (ebreak),
        .imm           (imm)
    );

    task automatic compare_value(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
        if (actual !== expected) begin
            $display("** Error at %0d ns: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_idle_strobes;
        compare_value("reg_wen", 64'd0, reg_wen);
        compare_value("mem_read", 64'd0, mem_read);
        compare_value("mem_write", 64'd0, mem_write);
        compare_value("branch", 64'd0, branch);
        compare_value("jump", 64'd0, jump);
    endtask

    task automatic check_output;
        int k;
        int due;
        int errors_before;
        if (idx_q.size() > 0 && cycle > due_q[0]) begin
            k = idx_q.pop_front();
            due = due_q.pop_front();
            $display("test %0d: no out_valid at cycle %0d for inst %h", k, due, vec[k][0][31:0]);
            error_count++;
            fail_count++;
        end
        if (!out_valid) begin
            check_idle_strobes();
        end else if (idx_q.size() == 0) begin
            $display("extra out_valid pulse at %0d ns with no instruction in flight", $time);
            error_count++;
        end else begin
            k = idx_q.pop_front();
            due = due_q.pop_front();
            errors_before = error_count;
            compare_value("out_valid cycle", due, cycle);
            compare_value("reg_wen", vec[k][1], reg_wen);
            compare_value("rd", vec[k][2], rd);
            compare_value("rs1", vec[k][3], rs1);
            compare_value("rs2", vec[k][4], rs2);
            compare_value("alu_op", vec[k][5], alu_op);
            compare_value("alu_src", vec[k][6], alu_src);
            compare_value("imm", vec[k][7], imm);
            compare_value("branch", vec[k][8], branch);
            compare_value("jump", vec[k][9], jump);
            compare_value("jalr", vec[k][10], jalr);
            compare_value("mem_read", vec[k][11], mem_read);
            compare_value("mem_write", vec[k][12], mem_write);
            compare_value("mem_size", vec[k][13], mem_size);
            compare_value("load_unsigned", vec[k][14], load_unsigned);
            compare_value("word_op", vec[k][15], word_op);
            compare_value("illegal", vec[k][16], illegal);
            compare_value("ebreak", vec[k][17], ebreak);
            if (error_count == errors_before) begin
                pass_count++;
                $display("test %0d inst %h: ok", k, vec[k][0][31:0]);
            end else begin
                fail_count++;
                $display("test %0d inst %h: mismatch", k, vec[k][0][31:0]);
            end
        end
    endtask

    task automatic next_cycle;
        @(negedge clk);
        check_output();
    endtask

    task automatic load_tests;
        int    fd;
        int    code;
        string line;
        fd = $fopen("decoder_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open decoder_tests.txt");
            error_count++;
        end else begin
            while (!$feof(fd) && num_tests < MAX_TESTS) begin
                code = $fgets(line, fd);
                if (code > 0 && line.len() > 0 && line[0] != "#") begin
                    code = $sscanf(line,
                        "%h %d %d %d %d %d %d %h %d %d %d %d %d %d %d %d %d %d",
                        vec[num_tests][0], vec[num_tests][1], vec[num_tests][2],
                        vec[num_tests][3], vec[num_tests][4], vec[num_tests][5],
                        vec[num_tests][6], vec[num_tests][7], vec[num_tests][8],
                        vec[num_tests][9], vec[num_tests][10], vec[num_tests][11],
                        vec[num_tests][12], vec[num_tests][13], vec[num_tests][14],
                        vec[num_tests][15], vec[num_tests][16], vec[num_tests][17]);
                    if (code == 18)
                        num_tests++;
                end
            end
            $fclose(fd);
            if (num_tests == 0) begin
                $display("decoder_tests.txt holds no usable test lines");
                error_count++;
            end
        end
    endtask

    initial begin
        int k;
        int g;
        int gap;
        int waited;
        reset = 1'b1;
        inst_valid = 1'b0;
        inst = '0;
        load_tests();
        for (k = 0; k < 3; k++)
            @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (k = 0; k < 4; k++)
            next_cycle();   // quiet window before the first strobe
        for (k = 0; k < num_tests; k++) begin
            gap = (k < 4) ? 0 : $unsigned($random(seed)) % 3;   // first few back to back
            next_cycle();
            inst = vec[k][0][`INST_WIDTH-1:0];
            inst_valid = 1'b1;
            idx_q.push_back(k);
            due_q.push_back(cycle + LATENCY);
            for (g = 0; g < gap; g++) begin
                next_cycle();
                inst_valid = 1'b0;
            end
        end
        next_cycle();
        inst_valid = 1'b0;
        waited = 0;
        while (idx_q.size() > 0 && waited < TIMEOUT_CYCLES) begin
            next_cycle();
            waited++;
        end
        if (idx_q.size() > 0) begin
            $display("timeout: %0d instructions got no out_valid within %0d cycles",
                     idx_q.size(), TIMEOUT_CYCLES);
            error_count++;
            fail_count += idx_q.size();
        end
        for (k = 0; k < 4; k++)
            next_cycle();   // catch stray trailing pulses
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 num_tests, pass_count, fail_count, error_count);
        if (error_count == 0 && num_tests > 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rv_decoder_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_decoder_config.svh"

module rv_decoder_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   inst_valid,
    input  rv_isa_pkg::inst_t      inst,
    output logic                   out_valid,
    output logic                   reg_wen,
    output rv_isa_pkg::reg_addr_t  rd,
    output rv_isa_pkg::reg_addr_t  rs1,
    output rv_isa_pkg::reg_addr_t  rs2,
    output rv_ctrl_pkg::alu_op_t   alu_op,
    output rv_ctrl_pkg::alu_src_t  alu_src,
    output logic                   branch,
    output logic                   jump,
    output logic                   jalr,
    output logic                   mem_read,
    output logic                   mem_write,
    output rv_ctrl_pkg::mem_size_t mem_size,
    output logic                   load_unsigned,
    output logic                   word_op,
    output logic                   illegal,
    output logic                   ebreak,
    output logic [`XLEN-1:0]       imm
);

    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    ctrl_t ctrl_d;
    ctrl_t ctrl_q;
    inst_t inst_q;
    logic  stage_valid;

    ctrl_decode decode_i (
        .inst (inst),
        .ctrl (ctrl_d)
    );

    decode_pipe_reg #(.payload_t(ctrl_t)) ctrl_stage_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (inst_valid),
        .in_data   (ctrl_d),
        .out_valid (stage_valid),
        .out_data  (ctrl_q)
    );

    // raw bits travel alongside for immediate extraction
    decode_pipe_reg #(.payload_t(inst_t)) inst_stage_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (inst_valid),
        .in_data   (inst),
        .out_valid (),
        .out_data  (inst_q)
    );

    imm_gen imm_gen_i (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (stage_valid),
        .ctrl_in       (ctrl_q),
        .inst          (inst_q),
        .out_valid     (out_valid),
        .reg_wen       (reg_wen),
        .rd            (rd),
        .rs1           (rs1),
        .rs2           (rs2),
        .alu_op        (alu_op),
        .alu_src       (alu_src),
        .branch        (branch),
        .jump          (jump),
        .jalr          (jalr),
        .mem_read      (mem_read),
        .mem_write     (mem_write),
        .mem_size      (mem_size),
        .load_unsigned (load_unsigned),
        .word_op       (word_op),
        .illegal       (illegal),
        .ebreak        (ebreak),
        .imm           (imm)
    );

endmodule

`default_nettype wire

//--- imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_decoder_config.svh"

module imm_gen (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   in_valid,
    input  rv_ctrl_pkg::ctrl_t     ctrl_in,
    input  rv_isa_pkg::inst_t      inst,
    output logic                   out_valid,
    output logic                   reg_wen,
    output rv_isa_pkg::reg_addr_t  rd,
    output rv_isa_pkg::reg_addr_t  rs1,
    output rv_isa_pkg::reg_addr_t  rs2,
    output rv_ctrl_pkg::alu_op_t   alu_op,
    output rv_ctrl_pkg::alu_src_t  alu_src,
    output logic                   branch,
    output logic                   jump,
    output logic                   jalr,
    output logic                   mem_read,
    output logic                   mem_write,
    output rv_ctrl_pkg::mem_size_t mem_size,
    output logic                   load_unsigned,
    output logic                   word_op,
    output logic                   illegal,
    output logic                   ebreak,
    output logic [`XLEN-1:0]       imm
);

    import rv_ctrl_pkg::*;

    logic [`XLEN-1:0] imm_d;

    always_comb begin
        case (ctrl_in.imm_fmt)
            IMM_I: imm_d = {{(`XLEN-12){inst[31]}}, inst[31:20]};
            IMM_S: imm_d = {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
            IMM_B: imm_d = {{(`XLEN-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            IMM_U: imm_d = {{(`XLEN-32){inst[31]}}, inst[31:12], 12'b0};
            IMM_J: imm_d = {{(`XLEN-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            IMM_SHAMT: begin
                if (ctrl_in.word_op)
                    imm_d = {{(`XLEN-5){1'b0}}, inst[24:20]};
                else
                    imm_d = {{(`XLEN-6){1'b0}}, inst[25:20]};
            end
            default: imm_d = '0;   // none, and illegal
        endcase
    end

    // strobes only live while the stage is valid
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            reg_wen   <= 1'b0;
            branch    <= 1'b0;
            jump      <= 1'b0;
            jalr      <= 1'b0;
            mem_read  <= 1'b0;
            mem_write <= 1'b0;
            illegal   <= 1'b0;
            ebreak    <= 1'b0;
        end else begin
            out_valid <= in_valid;
            reg_wen   <= in_valid & ctrl_in.reg_wen;
            branch    <= in_valid & ctrl_in.branch;
            jump      <= in_valid & ctrl_in.jump;
            jalr      <= in_valid & ctrl_in.jalr;
            mem_read  <= in_valid & ctrl_in.mem_read;
            mem_write <= in_valid & ctrl_in.mem_write;
            illegal   <= in_valid & ctrl_in.illegal;
            ebreak    <= in_valid & ctrl_in.ebreak;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            rd            <= ctrl_in.rd;
            rs1           <= ctrl_in.rs1;
            rs2           <= ctrl_in.rs2;
            alu_op        <= ctrl_in.alu_op;
            alu_src       <= ctrl_in.alu_src;
            mem_size      <= ctrl_in.mem_size;
            load_unsigned <= ctrl_in.load_unsigned;
            word_op       <= ctrl_in.word_op;
            imm           <= imm_d;
        end
    end

endmodule

`default_nettype wire

//--- decode_pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none

module decode_pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;   // one-cycle tag per strobe
        end
    end

    // holds last capture while idle
    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_data <= in_data;
        end
    end

endmodule

`default_nettype wire

//--- ctrl_decode.sv
`timescale 1ns/1ps
`default_nettype none

module ctrl_decode (
    input  rv_isa_pkg::inst_t  inst,
    output rv_ctrl_pkg::ctrl_t ctrl
);

    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    opcode_t   opcode;
    funct3_t   funct3;
    funct7_t   funct7;
    funct7_t   shift_f7;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    logic      word_grp;
    logic      bad;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rd     = inst[11:7];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    assign word_grp = (opcode == OP_REG_W) || (opcode == OP_IMM_W);
    // 64-bit shifts use inst[25] as shamt[5]
    assign shift_f7 = word_grp ? funct7 : {inst[31:26], 1'b0};

    always_comb begin
        ctrl = '0;
        bad  = 1'b0;
        if (inst == INST_EBREAK) begin
            ctrl.ebreak = 1'b1;
        end else begin
            case (opcode)
                OP_REG, OP_REG_W: begin
                    ctrl.reg_wen = 1'b1;
                    ctrl.rd      = rd;
                    ctrl.rs1     = rs1;
                    ctrl.rs2     = rs2;
                    ctrl.word_op = word_grp;
                    if (funct7 == FUNCT7_MULDIV) begin
                        case (funct3)
                            3'b000:  ctrl.alu_op = ALU_MUL;
                            3'b100:  ctrl.alu_op = ALU_DIV;
                            3'b101:  ctrl.alu_op = ALU_DIVU;
                            3'b110:  ctrl.alu_op = ALU_REM;
                            3'b111:  ctrl.alu_op = ALU_REMU;
                            default: bad = 1'b1;   // mulh family not supported
                        endcase
                    end else if (funct7 == '0 || funct7 == FUNCT7_ALT) begin
                        case (funct3)
                            3'b000:  ctrl.alu_op = (funct7 == FUNCT7_ALT) ? ALU_SUB : ALU_ADD;
                            3'b001:  ctrl.alu_op = ALU_SLL;
                            3'b010:  ctrl.alu_op = ALU_SLT;
                            3'b011:  ctrl.alu_op = ALU_SLTU;
                            3'b100:  ctrl.alu_op = ALU_XOR;
                            3'b101:  ctrl.alu_op = (funct7 == FUNCT7_ALT) ? ALU_SRA : ALU_SRL;
                            3'b110:  ctrl.alu_op = ALU_OR;
                            default: ctrl.alu_op = ALU_AND;
                        endcase
                        if (funct7 == FUNCT7_ALT && funct3 != 3'b000 && funct3 != 3'b101)
                            bad = 1'b1;
                        if (word_grp && !(funct3 inside {3'b000, 3'b001, 3'b101}))
                            bad = 1'b1;   // no word slt/xor/or/and
                    end else begin
                        bad = 1'b1;
                    end
                end
                OP_IMM, OP_IMM_W: begin
                    ctrl.reg_wen = 1'b1;
                    ctrl.rd      = rd;
                    ctrl.rs1     = rs1;
                    ctrl.alu_src = SRC_IMM;
                    ctrl.imm_fmt = IMM_I;
                    ctrl.word_op = word_grp;
                    case (funct3)
                        3'b000: ctrl.alu_op = ALU_ADD;
                        3'b010: ctrl.alu_op = ALU_SLT;
                        3'b011: ctrl.alu_op = ALU_SLTU;
                        3'b100: ctrl.alu_op = ALU_XOR;
                        3'b110: ctrl.alu_op = ALU_OR;
                        3'b111: ctrl.alu_op = ALU_AND;
                        3'b001: begin
                            ctrl.alu_op  = ALU_SLL;
                            ctrl.imm_fmt = IMM_SHAMT;
                            bad          = (shift_f7 != '0);
                        end
                        default: begin   // srli / srai
                            ctrl.alu_op  = (shift_f7 == FUNCT7_ALT) ? ALU_SRA : ALU_SRL;
                            ctrl.imm_fmt = IMM_SHAMT;
                            bad          = (shift_f7 != '0) && (shift_f7 != FUNCT7_ALT);
                        end
                    endcase
                    if (word_grp && !(funct3 inside {3'b000, 3'b001, 3'b101}))
                        bad = 1'b1;
                end
                OP_LOAD: begin
                    ctrl.reg_wen       = 1'b1;
                    ctrl.rd            = rd;
                    ctrl.rs1           = rs1;
                    ctrl.alu_src       = SRC_IMM;
                    ctrl.imm_fmt       = IMM_I;
                    ctrl.mem_read      = 1'b1;
                    ctrl.mem_size      = mem_size_t'(funct3[1:0]);
                    ctrl.load_unsigned = funct3[2];
                    bad                = (funct3 == 3'b111);   // no ldu
                end
                OP_STORE: begin
                    ctrl.rs1       = rs1;
                    ctrl.rs2       = rs2;
                    ctrl.alu_src   = SRC_IMM;
                    ctrl.imm_fmt   = IMM_S;
                    ctrl.mem_write = 1'b1;
                    ctrl.mem_size  = mem_size_t'(funct3[1:0]);
                    bad            = funct3[2];
                end
                OP_BRANCH: begin
                    ctrl.rs1     = rs1;
                    ctrl.rs2     = rs2;
                    ctrl.imm_fmt = IMM_B;
                    ctrl.branch  = 1'b1;
                    case (funct3)
                        3'b000:  ctrl.alu_op = ALU_BEQ;
                        3'b001:  ctrl.alu_op = ALU_BNE;
                        3'b100:  ctrl.alu_op = ALU_BLT;
                        3'b101:  ctrl.alu_op = ALU_BGE;
                        3'b110:  ctrl.alu_op = ALU_BLTU;
                        3'b111:  ctrl.alu_op = ALU_BGEU;
                        default: bad = 1'b1;
                    endcase
                end
                OP_JAL: begin
                    ctrl.reg_wen = 1'b1;
                    ctrl.rd      = rd;
                    ctrl.alu_src = SRC_PC_FOUR;   // link value
                    ctrl.imm_fmt = IMM_J;
                    ctrl.jump    = 1'b1;
                end
                OP_JALR: begin
                    ctrl.reg_wen = 1'b1;
                    ctrl.rd      = rd;
                    ctrl.rs1     = rs1;
                    ctrl.alu_src = SRC_PC_FOUR;
                    ctrl.imm_fmt = IMM_I;
                    ctrl.jump    = 1'b1;
                    ctrl.jalr    = 1'b1;
                    bad          = (funct3 != 3'b000);
                end
                OP_LUI, OP_AUIPC: begin
                    ctrl.reg_wen = 1'b1;
                    ctrl.rd      = rd;
                    ctrl.alu_src = (opcode == OP_LUI) ? SRC_IMM : SRC_PC_IMM;
                    ctrl.imm_fmt = IMM_U;
                end
                default: bad = 1'b1;
            endcase
        end
        // unknown encodings collapse to a bare flag
        if (bad) begin
            ctrl         = '0;
            ctrl.illegal = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- rv_ctrl_pkg.sv
`default_nettype none

package rv_ctrl_pkg;

    typedef enum logic [4:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL,
        ALU_SRA, ALU_MUL, ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU, ALU_BEQ, ALU_BNE, ALU_BLT,
        ALU_BGE, ALU_BLTU, ALU_BGEU
    } alu_op_t;

    // second operand source
    typedef enum logic [1:0] {SRC_REG, SRC_IMM, SRC_PC_FOUR, SRC_PC_IMM} alu_src_t;

    typedef enum logic [2:0] {
        IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J, IMM_SHAMT
    } imm_fmt_t;

    typedef enum logic [1:0] {SIZE_BYTE, SIZE_HALF, SIZE_WORD, SIZE_DOUBLE} mem_size_t;

    typedef struct packed {
        logic                  reg_wen;
        rv_isa_pkg::reg_addr_t rd;
        rv_isa_pkg::reg_addr_t rs1;
        rv_isa_pkg::reg_addr_t rs2;
        alu_op_t               alu_op;
        alu_src_t              alu_src;
        imm_fmt_t              imm_fmt;
        logic                  branch;
        logic                  jump;
        logic                  jalr;
        logic                  mem_read;
        logic                  mem_write;
        mem_size_t             mem_size;
        logic                  load_unsigned;
        logic                  word_op;        // result truncated to 32 bits
        logic                  illegal;
        logic                  ebreak;
    } ctrl_t;

endpackage

`default_nettype wire

//--- rv_isa_pkg.sv
`default_nettype none

`include "rv_decoder_config.svh"

package rv_isa_pkg;

    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;
    typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [`INST_WIDTH-1:0] inst_t;

    // major opcodes, inst[6:0]
    localparam opcode_t OP_REG    = 7'b0110011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_REG_W  = 7'b0111011;   // 32-bit word ops
    localparam opcode_t OP_IMM_W  = 7'b0011011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;

    // full encoding, all other fields zero
    localparam inst_t INST_EBREAK = 32'h0010_0073;

    localparam funct7_t FUNCT7_MULDIV = 7'b0000001;
    localparam funct7_t FUNCT7_ALT    = 7'b0100000;   // sub, sra

endpackage

`default_nettype wire

//--- rv_decoder_config.svh
`ifndef RV_DECODER_CONFIG_SVH
`define RV_DECODER_CONFIG_SVH

// data path width, rv64
`define XLEN 64

// base instruction length, no compressed support
`define INST_WIDTH 32

// 32 integer registers
`define REG_ADDR_WIDTH 5

`endif
